//--- sim.f
hdl/ooo_pkg.sv
hdl/ooo_if.sv
hdl/issue_dispatcher.sv
hdl/exec_unit.sv
hdl/cdb_arbiter.sv
hdl/reorder_buffer.sv
hdl/ooo_core_top.sv
tests/ooo_core_properties.sv
tests/ooo_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the ooo core testbench with verilator, runs it, and looks for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module ooo_core_tb -o ooo_core_sim -f sim.f; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/ooo_core_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "All tests passed" <<< "$sim_output"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- tests/ooo_core_tb.sv
// one seeded run of directed, rob-fill and random traffic; the model tracks commits at the falling edge
`timescale 1ns/1ps

module ooo_core_tb;
    import ooo_pkg::*;

    localparam int RANDOM_COUNT = 300;
    // random plus about 75 directed and stall slots, 8 cycles each, doubled for back-pressure
    localparam int CYCLE_LIMIT  = (RANDOM_COUNT + 75) * 16;

    logic              clk = 1'b0;
    logic              reset;
    logic              in_valid;
    logic              in_ready;
    alu_op_e           in_op;
    logic [REG_W-1:0]  in_dest;
    logic [DATA_W-1:0] in_a;
    logic [DATA_W-1:0] in_b;
    logic              commit_valid;
    logic              commit_ready = 1'b1;
    logic [TAG_W-1:0]  commit_tag;
    logic [REG_W-1:0]  commit_dest;
    logic [DATA_W-1:0] commit_value;

    // reference model, oldest instruction at the front
    logic [DATA_W-1:0] exp_value_q [$];
    logic [REG_W-1:0]  exp_dest_q [$];
    logic [DATA_W-1:0] exp_value;   // front, valid for the next rising edge
    logic [REG_W-1:0]  exp_dest;
    logic [TAG_W-1:0]  exp_tag;     // commits so far, mod ROB_DEPTH
    int                exp_count;   // outstanding instructions
    int                committed_total;
    int                cycle_count = 0;
    logic              random_ready;  // commit_ready from $random
    logic              hold_ready;    // commit_ready otherwise
    logic              ready_draw = 1'b1;  // random commit_ready for the next edge
    logic              fill_phase;
    integer            seed = 32'h1640;

    ooo_core_top ooo_core_top_inst (.*);

    always #4 clk = ~clk;

    function automatic logic [DATA_W-1:0] expected_result(input alu_op_e op,
                                                          input logic [DATA_W-1:0] a,
                                                          input logic [DATA_W-1:0] b);
        logic [2*DATA_W-1:0] product;
        product = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b};
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            default: return product[DATA_W-1:0];  // upper half dropped
        endcase
    endfunction

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // call just after a rising edge, returns just after the accepting edge
    task automatic send_instr(input alu_op_e op, input logic [REG_W-1:0] dest,
                              input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
        in_valid <= 1'b1;
        in_op    <= op;
        in_dest  <= dest;
        in_a     <= a;
        in_b     <= b;
        do @(negedge clk); while (!in_ready);  // ready settled, accepted on the next edge
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        do @(posedge clk); while (exp_value_q.size() != 0);
    endtask

    ////////////////////
    // model and checks
    ////////////////////

    always @(negedge clk) begin
        if (reset) begin
            exp_value_q.delete();
            exp_dest_q.delete();
            exp_value       = '0;
            exp_dest        = '0;
            exp_tag         = '0;
            exp_count       = 0;
            committed_total = 0;
        end else begin
            exp_count = exp_value_q.size();
            if (exp_count != 0) begin
                exp_value = exp_value_q[0];
                exp_dest  = exp_dest_q[0];
            end
            exp_tag = committed_total[TAG_W-1:0];  // head index follows the commit count
            if (commit_valid && commit_ready) begin  // retires on the coming edge
                committed_total++;
                if (exp_count != 0) begin
                    void'(exp_value_q.pop_front());
                    void'(exp_dest_q.pop_front());
                end
            end
            if (in_valid && in_ready) begin
                exp_value_q.push_back(expected_result(in_op, in_a, in_b));
                exp_dest_q.push_back(in_dest);
            end
        end
    end

    a_commit_expected: assert property (@(posedge clk) disable iff (reset)
        commit_valid && commit_ready |-> exp_count != 0)
        else begin
            $display("commit seen with no instruction outstanding");
            abort_run();
        end

    a_commit_value: assert property (@(posedge clk) disable iff (reset)
        commit_valid && commit_ready |-> commit_value == exp_value)
        else begin
            $display("CHECK FAILED commit_value got %h expected %h",
                     $sampled(commit_value), exp_value);
            abort_run();
        end

    a_commit_dest: assert property (@(posedge clk) disable iff (reset)
        commit_valid && commit_ready |-> commit_dest == exp_dest)
        else begin
            $display("CHECK FAILED commit_dest got %h expected %h",
                     $sampled(commit_dest), exp_dest);
            abort_run();
        end

    // program order, one tag step per commit
    a_commit_tag: assert property (@(posedge clk) disable iff (reset)
        commit_valid && commit_ready |-> commit_tag == exp_tag)
        else begin
            $display("CHECK FAILED commit_tag got %h expected %h",
                     $sampled(commit_tag), exp_tag);
            abort_run();
        end

    a_full_blocks: assert property (@(posedge clk) disable iff (reset)
        exp_count == ROB_DEPTH |-> !in_ready)
        else begin
            $display("CHECK FAILED in_ready got %h expected %h", $sampled(in_ready), 1'b0);
            abort_run();
        end

    // add-only fill keeps units free, so only a full rob may stall input
    a_fill_ready: assert property (@(posedge clk) disable iff (reset)
        fill_phase && !in_ready |-> exp_count == ROB_DEPTH)
        else begin
            $display("in_ready went low with only %0d instructions outstanding", exp_count);
            abort_run();
        end

    ////////////////////
    // stimulus
    ////////////////////

    // drawn on the falling edge, the instruction operands are drawn on the rising one
    always @(negedge clk) begin
        if (random_ready) begin
            ready_draw = ($random(seed) % 4) != 0;  // about 3 in 4 cycles
        end
    end

    always @(posedge clk) begin
        if (random_ready) begin
            commit_ready <= ready_draw;
        end else begin
            commit_ready <= hold_ready;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, core stopped making progress", cycle_count);
            abort_run();
        end
    end

    initial begin : stimulus
        alu_op_e           op;
        logic [REG_W-1:0]  dest;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_op        = OP_ADD;
        in_dest      = '0;
        in_a         = '0;
        in_b         = '0;
        random_ready = 1'b0;
        hold_ready   = 1'b1;
        fill_phase   = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // each opcode, with wrapping sums and overflowing products
        send_instr(OP_ADD, 5'd1, 32'hFFFF_FFFF, 32'h0000_0001);
        send_instr(OP_SUB, 5'd2, 32'h0000_0000, 32'h0000_0001);
        send_instr(OP_XOR, 5'd3, 32'hA5A5_0F0F, 32'h5A5A_FF00);
        send_instr(OP_MUL, 5'd4, 32'h0001_0000, 32'h0001_0000);
        send_instr(OP_MUL, 5'd5, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        // slow mul ahead of fast adds, they must wait behind it
        send_instr(OP_MUL, 5'd6, 32'h8765_4321, 32'hFEDC_BA98);
        for (int i = 0; i < 5; i++) begin
            send_instr(OP_ADD, REG_W'(7 + i), 32'(i), 32'h1000_0000);
        end
        wait_drain();

        // stall retire and fill every entry
        hold_ready <= 1'b0;
        fill_phase <= 1'b1;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            send_instr(OP_ADD, REG_W'($random(seed)), $random(seed), $random(seed));
        end
        repeat (2 * ROB_DEPTH) @(posedge clk);  // hold the stall a while
        fill_phase <= 1'b0;
        hold_ready <= 1'b1;
        wait_drain();

        // random mix under random commit back-pressure
        random_ready <= 1'b1;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            op   = alu_op_e'(2'($random(seed)));
            dest = REG_W'($random(seed));
            a    = $random(seed);
            b    = $random(seed);
            send_instr(op, dest, a, b);
        end
        random_ready <= 1'b0;
        wait_drain();

        // every accepted instruction retired, nothing may be left at the head
        @(negedge clk);
        if (!commit_valid) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("CHECK FAILED commit_valid got %h expected %h", commit_valid, 1'b0);
            abort_run();
        end
    end

endmodule

//--- tests/ooo_core_properties.sv
// bound into ooo_core_top; sees the top ports and the cdb only, reports through failing assertions
`timescale 1ns/1ps

module ooo_core_properties (
    input logic                        clk,
    input logic                        reset,
    input logic                        in_ready,
    input logic                        cdb_valid,
    input logic                        commit_valid,
    input logic                        commit_ready,
    input logic [ooo_pkg::TAG_W-1:0]   commit_tag,
    input logic [ooo_pkg::REG_W-1:0]   commit_dest,
    input logic [ooo_pkg::DATA_W-1:0]  commit_value
);

    ////////////////////
    // reset state
    ////////////////////

    // covers every reset edge after the first and the first cycle out of reset
    a_reset_quiet: assert property (@(posedge clk)
        $past(reset) |-> !commit_valid && !cdb_valid && in_ready)
        else $error("core not idle after reset");

    ////////////////////
    // commit back-pressure
    ////////////////////

    // a stalled head entry may not retract
    a_commit_valid_held: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid)
        else $error("commit_valid dropped while stalled");

    a_commit_payload_held: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=>
            $stable(commit_tag) && $stable(commit_dest) && $stable(commit_value))
        else $error("commit fields changed while stalled");

endmodule

bind ooo_core_top ooo_core_properties ooo_core_properties_inst (
    .clk          (clk),
    .reset        (reset),
    .in_ready     (in_ready),
    .cdb_valid    (cdb_valid),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit_tag   (commit_tag),
    .commit_dest  (commit_dest),
    .commit_value (commit_value)
);

//--- hdl/ooo_core_top.sv
// operands arrive already read; the commit port stands in for a register file, no flush or stores
`timescale 1ns/1ps

module ooo_core_top (
    input  logic                        clk,
    input  logic                        reset,
    // instruction input, program order
    input  logic                        in_valid,
    output logic                        in_ready,
    input  ooo_pkg::alu_op_e            in_op,
    input  logic [ooo_pkg::REG_W-1:0]   in_dest,
    input  logic [ooo_pkg::DATA_W-1:0]  in_a,
    input  logic [ooo_pkg::DATA_W-1:0]  in_b,
    // in-order retire
    output logic                        commit_valid,
    input  logic                        commit_ready,
    output logic [ooo_pkg::TAG_W-1:0]   commit_tag,
    output logic [ooo_pkg::REG_W-1:0]   commit_dest,
    output logic [ooo_pkg::DATA_W-1:0]  commit_value
);
    import ooo_pkg::*;

    ////////////////////
    // internal buses
    ////////////////////

    rob_alloc_if       alloc_bus ();
    issue_if           issue_bus [NUM_UNITS] ();
    result_if          result_bus [NUM_UNITS] ();

    logic              cdb_valid;  // registered in the arbiter
    logic [TAG_W-1:0]  cdb_tag;
    logic [DATA_W-1:0] cdb_value;

    issue_dispatcher issue_dispatcher_inst (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_op    (in_op),
        .in_dest  (in_dest),
        .in_a     (in_a),
        .in_b     (in_b),
        .alloc    (alloc_bus),
        .issue    (issue_bus)
    );

    // identical units, the dispatcher picks among them
    for (genvar g = 0; g < NUM_UNITS; g++) begin : g_unit
        exec_unit exec_unit_inst (
            .clk    (clk),
            .reset  (reset),
            .issue  (issue_bus[g]),
            .result (result_bus[g])
        );
    end

    cdb_arbiter cdb_arbiter_inst (
        .clk       (clk),
        .reset     (reset),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .result    (result_bus)
    );

    reorder_buffer reorder_buffer_inst (
        .clk          (clk),
        .reset        (reset),
        .alloc        (alloc_bus),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_value    (cdb_value),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_tag   (commit_tag),
        .commit_dest  (commit_dest),
        .commit_value (commit_value)
    );

endmodule

//--- hdl/reorder_buffer.sv
// circular rob, retires in order; no flush, and a full buffer refuses allocation even on a retire cycle
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                        clk,
    input  logic                        reset,
    rob_alloc_if.target                 alloc,
    input  logic                        cdb_valid,
    input  logic [ooo_pkg::TAG_W-1:0]   cdb_tag,
    input  logic [ooo_pkg::DATA_W-1:0]  cdb_value,
    output logic                        commit_valid,
    input  logic                        commit_ready,
    output logic [ooo_pkg::TAG_W-1:0]   commit_tag,
    output logic [ooo_pkg::REG_W-1:0]   commit_dest,
    output logic [ooo_pkg::DATA_W-1:0]  commit_value
);
    import ooo_pkg::*;

    ////////////////////
    // storage
    ////////////////////

    rob_state_e        state_q [ROB_DEPTH];  // per-entry status
    logic [REG_W-1:0]  dest_q  [ROB_DEPTH];
    logic [DATA_W-1:0] value_q [ROB_DEPTH];

    // extra msb is the wrap bit
    logic [TAG_W:0]    head;
    logic [TAG_W:0]    tail;
    logic [TAG_W-1:0]  head_idx;
    logic [TAG_W-1:0]  tail_idx;
    logic              full;
    logic              alloc_fire;
    logic              retire;

    assign head_idx = head[TAG_W-1:0];
    assign tail_idx = tail[TAG_W-1:0];

    // same slot, opposite lap -> every entry allocated
    assign full = (head_idx == tail_idx) && (head[TAG_W] != tail[TAG_W]);

    assign alloc.ready = !full;
    assign alloc.tag   = tail_idx;
    assign alloc_fire  = alloc.valid && alloc.ready;

    ////////////////////
    // commit port
    ////////////////////

    assign commit_valid = (state_q[head_idx] == ENTRY_DONE);  // oldest has its result
    assign commit_tag   = head_idx;
    assign commit_dest  = dest_q[head_idx];
    assign commit_value = value_q[head_idx];
    assign retire       = commit_valid && commit_ready;

    // allocate, write-back and retire touch different slots, so all three can go at once:
    // tail is EMPTY, the cdb target is BUSY, head is DONE
    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                state_q[i] <= ENTRY_EMPTY;
            end
        end else begin
            if (retire) begin
                state_q[head_idx] <= ENTRY_EMPTY;  // slot back to the pool
                head              <= head + 1;
            end
            if (alloc_fire) begin
                state_q[tail_idx] <= ENTRY_BUSY;
                tail              <= tail + 1;
            end
            if (cdb_valid) begin
                state_q[cdb_tag] <= ENTRY_DONE;
            end
        end
    end

    // payload, written only where state says it is meaningful
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            dest_q[tail_idx] <= alloc.dest;
        end
        if (cdb_valid) begin
            value_q[cdb_tag] <= cdb_value;  // result lands with its tag
        end
    end

endmodule

//--- hdl/cdb_arbiter.sv
// one result per cycle onto a registered cdb; round-robin so no unit starves
`timescale 1ns/1ps

module cdb_arbiter (
    input  logic                        clk,
    input  logic                        reset,
    output logic                        cdb_valid,
    output logic [ooo_pkg::TAG_W-1:0]   cdb_tag,
    output logic [ooo_pkg::DATA_W-1:0]  cdb_value,
    result_if.target                    result [ooo_pkg::NUM_UNITS]
);
    import ooo_pkg::*;

    logic [NUM_UNITS-1:0]         req;
    logic [NUM_UNITS-1:0]         gnt;
    logic [TAG_W-1:0]             tags   [NUM_UNITS];
    logic [DATA_W-1:0]            values [NUM_UNITS];
    logic [$clog2(NUM_UNITS)-1:0] ptr;   // highest priority this cycle
    logic [$clog2(NUM_UNITS)-1:0] win;
    logic [$clog2(NUM_UNITS)-1:0] idx;
    logic                         any;

    for (genvar g = 0; g < NUM_UNITS; g++) begin : g_req
        assign req[g]          = result[g].valid;
        assign tags[g]         = result[g].tag;
        assign values[g]       = result[g].value;
        assign result[g].ready = gnt[g];  // unit drops its result on this
    end

    ////////////////////
    // grant
    ////////////////////

    always_comb begin
        any = 1'b0;
        win = ptr;
        gnt = '0;
        idx = ptr;
        for (int k = 0; k < NUM_UNITS; k++) begin
            if (!any && req[idx]) begin
                any = 1'b1;
                win = idx;
            end
            idx = idx + 1;
        end
        if (any) begin
            gnt[win] = 1'b1;
        end
    end

    // control, cdb_valid a cycle after grant
    always_ff @(posedge clk) begin
        if (reset) begin
            cdb_valid <= 1'b0;
            ptr       <= '0;
        end else begin
            cdb_valid <= any;
            if (any) ptr <= win + 1;  // last winner goes to the back
        end
    end

    // bus payload
    always_ff @(posedge clk) begin
        if (any) begin
            cdb_tag   <= tags[win];
            cdb_value <= values[win];
        end
    end

endmodule

//--- hdl/exec_unit.sv
// one instruction in flight; logic ops finish next cycle, MUL after MUL_STEPS cycles, low 32 bits kept
`timescale 1ns/1ps

module exec_unit (
    input  logic        clk,
    input  logic        reset,
    issue_if.target     issue,
    result_if.initiator result
);
    import ooo_pkg::*;

    unit_state_e          state;
    logic [MUL_STEPS-1:0] slice_done;  // one bit per finished multiplier slice, shifts left
    logic [TAG_W-1:0]     tag_q;
    logic [DATA_W-1:0]    acc_q;       // result, or running product
    logic [DATA_W-1:0]    mcand_q;     // multiplicand, pre-shifted for the next slice
    logic [DATA_W-1:0]    mplier_q;    // remaining multiplier bits, low slice next
    logic                 take;

    // add one slice of the shift-add product
    function automatic logic [DATA_W-1:0] mul_slice(
        input logic [DATA_W-1:0]             acc,
        input logic [DATA_W-1:0]             mcand,
        input logic [DATA_W/MUL_STEPS-1:0]   digit
    );
        return acc + mcand * DATA_W'(digit);
    endfunction

    assign issue.ready  = (state == UNIT_IDLE);
    assign take         = issue.valid && issue.ready;
    assign result.valid = (state == UNIT_HOLD);
    assign result.tag   = tag_q;
    assign result.value = acc_q;

    ////////////////////
    // control FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= UNIT_IDLE;
            slice_done <= '0;
        end else begin
            case (state)
                UNIT_IDLE: if (take) begin
                    if (issue.op == OP_MUL) begin
                        state      <= UNIT_MUL;
                        slice_done <= MUL_STEPS'(1);  // slice 0 done on the issue edge
                    end else begin
                        state <= UNIT_HOLD;
                    end
                end
                UNIT_MUL: begin
                    slice_done <= slice_done << 1;
                    if (slice_done[MUL_STEPS-2]) state <= UNIT_HOLD;  // last slice this cycle
                end
                UNIT_HOLD: if (result.ready) state <= UNIT_IDLE;  // granted, free again
                default: state <= UNIT_IDLE;
            endcase
        end
    end

    ////////////////////
    // datapath
    ////////////////////

    always_ff @(posedge clk) begin
        if (take) begin
            tag_q <= issue.tag;
            case (issue.op)
                OP_ADD:  acc_q <= issue.a + issue.b;
                OP_SUB:  acc_q <= issue.a - issue.b;
                OP_XOR:  acc_q <= issue.a ^ issue.b;
                default: acc_q <= mul_slice('0, issue.a, issue.b[DATA_W/MUL_STEPS-1:0]);
            endcase
            mcand_q  <= issue.a << (DATA_W / MUL_STEPS);
            mplier_q <= issue.b >> (DATA_W / MUL_STEPS);
        end else if (state == UNIT_MUL) begin
            acc_q    <= mul_slice(acc_q, mcand_q, mplier_q[DATA_W/MUL_STEPS-1:0]);
            mcand_q  <= mcand_q << (DATA_W / MUL_STEPS);   // bits past 32 drop out
            mplier_q <= mplier_q >> (DATA_W / MUL_STEPS);
        end
    end

endmodule

//--- hdl/issue_dispatcher.sv
// accepts one instruction per cycle only when a rob slot and an idle unit exist together
`timescale 1ns/1ps

module issue_dispatcher (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  ooo_pkg::alu_op_e            in_op,
    input  logic [ooo_pkg::REG_W-1:0]   in_dest,
    input  logic [ooo_pkg::DATA_W-1:0]  in_a,
    input  logic [ooo_pkg::DATA_W-1:0]  in_b,
    rob_alloc_if.initiator              alloc,
    issue_if.initiator                  issue [ooo_pkg::NUM_UNITS]
);
    import ooo_pkg::*;

    logic [NUM_UNITS-1:0]         idle;    // issue ready per unit
    logic [NUM_UNITS-1:0]         sel_oh;  // chosen unit, one-hot
    logic [$clog2(NUM_UNITS)-1:0] ptr;     // round-robin start position
    logic [$clog2(NUM_UNITS)-1:0] sel;
    logic [$clog2(NUM_UNITS)-1:0] idx;
    logic                         found;
    logic                         fire;

    ////////////////////
    // unit selection
    ////////////////////

    // first idle unit at or after ptr, wrapping
    always_comb begin
        found  = 1'b0;
        sel    = ptr;
        sel_oh = '0;
        idx    = ptr;
        for (int k = 0; k < NUM_UNITS; k++) begin
            if (!found && idle[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
            idx = idx + 1;  // wraps naturally, NUM_UNITS is a power of two
        end
        if (found) begin
            sel_oh[sel] = 1'b1;
        end
    end

    assign in_ready = alloc.ready && found;  // both sides must be able to take it
    assign fire     = in_valid && in_ready;

    // rob allocation, same cycle as the issue
    assign alloc.valid = fire;
    assign alloc.dest  = in_dest;

    ////////////////////
    // issue ports
    ////////////////////

    for (genvar g = 0; g < NUM_UNITS; g++) begin : g_issue
        assign idle[g]        = issue[g].ready;
        assign issue[g].valid = fire && sel_oh[g];
        assign issue[g].tag   = alloc.tag;  // rob tail becomes the instruction tag
        assign issue[g].op    = in_op;
        assign issue[g].a     = in_a;
        assign issue[g].b     = in_b;
    end

    // move past the unit just used so work spreads out
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (fire) begin
            ptr <= sel + 1;
        end
    end

endmodule

//--- hdl/ooo_if.sv
// valid/ready bundles inside the core; a driver holds its payload until ready is seen at the edge
`timescale 1ns/1ps

// dispatcher asks the rob for a slot, rob answers with its tail tag
interface rob_alloc_if;
    import ooo_pkg::*;
    logic             valid;
    logic             ready;  // rob not full
    logic [REG_W-1:0] dest;
    logic [TAG_W-1:0] tag;    // current tail index
    modport initiator (output valid, dest, input ready, tag);
    modport target (input valid, dest, output ready, tag);
endinterface

// dispatcher to one execution unit
interface issue_if;
    import ooo_pkg::*;
    logic              valid;
    logic              ready;  // unit idle
    logic [TAG_W-1:0]  tag;
    alu_op_e           op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    modport initiator (output valid, tag, op, a, b, input ready);
    modport target (input valid, tag, op, a, b, output ready);
endinterface

// one execution unit to the cdb arbiter, ready is the grant
interface result_if;
    import ooo_pkg::*;
    logic              valid;
    logic              ready;
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] value;
    modport initiator (output valid, tag, value, input ready);
    modport target (input valid, tag, value, output ready);
endinterface

//--- hdl/ooo_pkg.sv
// shared sizes and enums; TAG_W must equal log2(ROB_DEPTH) and DATA_W must split evenly into MUL_STEPS slices
package ooo_pkg;

    ////////////////////
    // sizes
    ////////////////////

    localparam int NUM_UNITS = 4;   // execution units, power of two for the rotating pointers
    localparam int ROB_DEPTH = 16;  // re-order buffer entries
    localparam int TAG_W     = 4;   // rob index width
    localparam int DATA_W    = 32;  // operand and result width
    localparam int REG_W     = 5;   // architectural destination register
    localparam int MUL_STEPS = 4;   // multiply iterations, 8 multiplier bits each

    ////////////////////
    // enums
    ////////////////////

    // opcodes, all of them write a register
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_XOR = 2'd2,
        OP_MUL = 2'd3
    } alu_op_e;

    // rob entry status
    typedef enum logic [1:0] {
        ENTRY_EMPTY = 2'd0,  // slot free
        ENTRY_BUSY  = 2'd1,  // allocated, waiting on the cdb
        ENTRY_DONE  = 2'd2   // result captured, may retire
    } rob_state_e;

    // execution unit FSM
    typedef enum logic [1:0] {
        UNIT_IDLE = 2'd0,  // ready for a new instruction
        UNIT_MUL  = 2'd1,  // iterating the multiply
        UNIT_HOLD = 2'd2   // result waiting for a cdb grant
    } unit_state_e;

endpackage
